//--- logic/mips_core_pkg.sv
`default_nettype none

package mips_core_pkg;

    localparam int WORD_W      = 32;
    localparam int REG_AW      = 5;
    localparam int NUM_GPR     = 1 << REG_AW;
    localparam int QUEUE_DEPTH = 4;
    localparam int QPTR_W      = $clog2(QUEUE_DEPTH);

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [REG_AW-1:0] reg_addr_t;

    localparam reg_addr_t GPR_RA = 5'd31;  // link register.

    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_REGIMM  = 6'h01;
    localparam logic [5:0] OP_J       = 6'h02;
    localparam logic [5:0] OP_JAL     = 6'h03;
    localparam logic [5:0] OP_BEQ     = 6'h04;
    localparam logic [5:0] OP_BNE     = 6'h05;
    localparam logic [5:0] OP_BLEZ    = 6'h06;
    localparam logic [5:0] OP_BGTZ    = 6'h07;
    localparam logic [5:0] OP_ADDI    = 6'h08;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    localparam logic [5:0] SP_SLL  = 6'h00;
    localparam logic [5:0] SP_SRL  = 6'h02;
    localparam logic [5:0] SP_SRA  = 6'h03;
    localparam logic [5:0] SP_SLLV = 6'h04;
    localparam logic [5:0] SP_SRLV = 6'h06;
    localparam logic [5:0] SP_SRAV = 6'h07;
    localparam logic [5:0] SP_JR   = 6'h08;
    localparam logic [5:0] SP_JALR = 6'h09;
    localparam logic [5:0] SP_MOVZ = 6'h0a;
    localparam logic [5:0] SP_MOVN = 6'h0b;
    localparam logic [5:0] SP_ADD  = 6'h20;
    localparam logic [5:0] SP_ADDU = 6'h21;
    localparam logic [5:0] SP_SUB  = 6'h22;
    localparam logic [5:0] SP_SUBU = 6'h23;
    localparam logic [5:0] SP_AND  = 6'h24;
    localparam logic [5:0] SP_OR   = 6'h25;
    localparam logic [5:0] SP_XOR  = 6'h26;
    localparam logic [5:0] SP_NOR  = 6'h27;
    localparam logic [5:0] SP_SLT  = 6'h2a;
    localparam logic [5:0] SP_SLTU = 6'h2b;

    // bit 0 of the rt field selects the >= 0 test.
    localparam logic [4:0] RI_BLTZ   = 5'h00;
    localparam logic [4:0] RI_BGEZ   = 5'h01;
    localparam logic [4:0] RI_BLTZAL = 5'h10;
    localparam logic [4:0] RI_BGEZAL = 5'h11;

    typedef enum logic [3:0] {
        NOP, ADD, SUB, AND, OR, XOR, NOR, SLT, SLTU, SLL, SRL, SRA, MOV, LINK
    } alu_op_e;

    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        logic [5:0] funct;
    } r_view_t;

    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm16;
    } i_view_t;

    typedef union packed {
        r_view_t r;
        i_view_t i;
    } inst_u;

    typedef struct packed {
        word_t pc;
        inst_u inst;
    } fetch_t;

    typedef struct packed {
        logic      valid;
        logic      illegal;
        word_t     pc;
        alu_op_e   alu_op;
        word_t     opr1;
        word_t     opr2;
        logic      wr_en;
        reg_addr_t wr_addr;
        logic      is_branch;
        logic      br_taken;
        word_t     br_target;
        logic      mov_on_zero;
        logic      is_mov;
    } dec_t;

    typedef struct packed {
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     data;
    } fwd_t;

    typedef struct packed {
        word_t     pc;
        logic      illegal;
        logic      wr_en;
        reg_addr_t wr_addr;
        word_t     wr_data;
        logic      is_branch;
        logic      br_taken;
        word_t     br_target;
    } retire_t;

endpackage

`default_nettype wire

//--- logic/inst_queue.sv
`timescale 1ns/10ps
`default_nettype none

module inst_queue (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  in_valid,
    input  mips_core_pkg::fetch_t in_inst,
    output logic                  out_valid,
    output mips_core_pkg::fetch_t out_inst,
    output logic                  credit
);
    import mips_core_pkg::*;

    fetch_t            mem [QUEUE_DEPTH];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QPTR_W:0]   count;
    logic              pop;

    assign pop       = (count != '0);  // drain one entry every cycle.
    assign out_valid = pop;
    assign out_inst  = mem[rd_ptr];
    assign credit    = pop;            // slot freed, hand it back.

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (in_valid) begin
                wr_ptr <= wr_ptr + QPTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + QPTR_W'(1);
            end
            case ({in_valid, pop})
                2'b10:   count <= count + (QPTR_W+1)'(1);
                2'b01:   count <= count - (QPTR_W+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  mips_core_pkg::fetch_t    in_inst,
    output mips_core_pkg::reg_addr_t r1_addr,
    input  mips_core_pkg::word_t     r1_data,
    output mips_core_pkg::reg_addr_t r2_addr,
    input  mips_core_pkg::word_t     r2_data,
    input  mips_core_pkg::fwd_t      ex_fwd,
    input  mips_core_pkg::fwd_t      wb_fwd,
    output mips_core_pkg::dec_t      dec
);
    import mips_core_pkg::*;

    inst_u inst;
    word_t pc4;
    word_t sign_ext;
    word_t zero_ext;
    word_t lui_ext;
    word_t br_rel;
    word_t rs_val;
    word_t rt_val;
    logic  rs_lez;
    logic  known;
    logic  src1_imm;
    logic  src2_imm;
    word_t imm;
    dec_t  d;

    // newest value wins: ex, then wb, then the register file.
    function automatic word_t fwd_sel(reg_addr_t a, word_t rf_val, fwd_t ex, fwd_t wb);
        word_t v;
        v = rf_val;
        if (a != '0 && wb.wr_en && wb.wr_addr == a) begin
            v = wb.data;
        end
        if (a != '0 && ex.wr_en && ex.wr_addr == a) begin
            v = ex.data;
        end
        return v;
    endfunction

    function automatic alu_op_e funct_alu(logic [5:0] funct);
        case (funct)
            SP_SLL, SP_SLLV: return SLL;
            SP_SRL, SP_SRLV: return SRL;
            SP_SRA, SP_SRAV: return SRA;
            SP_ADD, SP_ADDU: return ADD;  // no overflow trap.
            SP_SUB, SP_SUBU: return SUB;
            SP_AND:          return AND;
            SP_OR:           return OR;
            SP_XOR:          return XOR;
            SP_NOR:          return NOR;
            SP_SLT:          return SLT;
            SP_SLTU:         return SLTU;
            SP_MOVZ, SP_MOVN: return MOV;
            SP_JALR:         return LINK;
            default:         return NOP;
        endcase
    endfunction

    function automatic alu_op_e imm_alu(logic [5:0] op);
        case (op)
            OP_SLTI:        return SLT;
            OP_SLTIU:       return SLTU;
            OP_ANDI:        return AND;
            OP_ORI, OP_LUI: return OR;
            OP_XORI:        return XOR;
            default:        return ADD;
        endcase
    endfunction

    assign inst     = in_inst.inst;
    assign pc4      = in_inst.pc + 32'd4;
    assign sign_ext = {{16{inst.i.imm16[15]}}, inst.i.imm16};
    assign zero_ext = {16'b0, inst.i.imm16};
    assign lui_ext  = {inst.i.imm16, 16'b0};
    assign br_rel   = pc4 + {sign_ext[29:0], 2'b00};

    assign r1_addr = inst.r.rs;
    assign r2_addr = inst.r.rt;
    assign rs_val  = fwd_sel(inst.r.rs, r1_data, ex_fwd, wb_fwd);
    assign rt_val  = fwd_sel(inst.r.rt, r2_data, ex_fwd, wb_fwd);
    assign rs_lez  = rs_val[31] || (rs_val == '0);

    always_comb begin
        known     = 1'b0;
        src1_imm  = 1'b0;
        src2_imm  = 1'b0;
        imm       = sign_ext;
        d         = '0;
        d.valid   = in_valid;
        d.pc      = in_inst.pc;
        d.wr_addr = inst.r.rd;

        case (inst.r.opcode)
            OP_SPECIAL: begin
                d.alu_op = funct_alu(inst.r.funct);
                case (inst.r.funct)
                    SP_SLL, SP_SRL, SP_SRA: begin
                        known    = (inst.r.rs == '0);
                        src1_imm = 1'b1;             // shift amount from sa.
                        imm      = word_t'(inst.r.sa);
                        d.wr_en  = 1'b1;
                    end
                    SP_SLLV, SP_SRLV, SP_SRAV, SP_ADD, SP_ADDU, SP_SUB, SP_SUBU,
                    SP_AND, SP_OR, SP_XOR, SP_NOR, SP_SLT, SP_SLTU: begin
                        known   = (inst.r.sa == '0);
                        d.wr_en = 1'b1;
                    end
                    SP_MOVZ, SP_MOVN: begin
                        known         = (inst.r.sa == '0);
                        d.wr_en       = 1'b1;
                        d.is_mov      = 1'b1;
                        d.mov_on_zero = (inst.r.funct == SP_MOVZ);
                    end
                    SP_JR, SP_JALR: begin
                        known = (inst.r.rt == '0) && (inst.r.sa == '0) &&
                                (inst.r.funct == SP_JALR || inst.r.rd == '0);
                        d.wr_en     = (inst.r.funct == SP_JALR);
                        d.is_branch = 1'b1;
                        d.br_taken  = 1'b1;
                        d.br_target = rs_val;
                    end
                    default: ;
                endcase
            end
            OP_REGIMM: begin
                d.wr_addr   = GPR_RA;
                d.is_branch = 1'b1;
                d.br_taken  = rs_val[31] ^ inst.i.rt[0];
                d.br_target = br_rel;
                case (inst.i.rt)
                    RI_BLTZ, RI_BGEZ: known = 1'b1;
                    RI_BLTZAL, RI_BGEZAL: begin
                        known    = 1'b1;
                        d.alu_op = LINK;
                        d.wr_en  = 1'b1;
                    end
                    default: ;
                endcase
            end
            OP_J, OP_JAL: begin
                known       = 1'b1;
                d.wr_addr   = GPR_RA;
                d.is_branch = 1'b1;
                d.br_taken  = 1'b1;
                d.br_target = {pc4[31:28], inst.i[25:0], 2'b00};
                if (inst.i.opcode == OP_JAL) begin
                    d.alu_op = LINK;
                    d.wr_en  = 1'b1;
                end
            end
            OP_BEQ, OP_BNE: begin
                known       = 1'b1;
                d.is_branch = 1'b1;
                d.br_taken  = (rs_val == rt_val) ^ inst.i.opcode[0];  // odd is bne.
                d.br_target = br_rel;
            end
            OP_BLEZ, OP_BGTZ: begin
                known       = (inst.i.rt == '0);
                d.is_branch = 1'b1;
                d.br_taken  = rs_lez ^ inst.i.opcode[0];
                d.br_target = br_rel;
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                known     = (inst.i.opcode != OP_LUI) || (inst.i.rs == '0);
                src2_imm  = 1'b1;
                d.alu_op  = imm_alu(inst.i.opcode);
                d.wr_en   = 1'b1;
                d.wr_addr = inst.i.rt;
                if (inst.i.opcode == OP_LUI) begin
                    imm = lui_ext;
                end else if (inst.i.opcode[2]) begin
                    imm = zero_ext;  // logical immediates.
                end
            end
            default: ;
        endcase

        if (!known) begin
            d.illegal   = 1'b1;
            d.alu_op    = NOP;
            d.wr_en     = 1'b0;
            d.is_branch = 1'b0;
            d.br_taken  = 1'b0;
            d.is_mov    = 1'b0;
        end

        d.opr1 = src1_imm ? imm : rs_val;
        d.opr2 = src2_imm ? imm : rt_val;
    end

    always_ff @(posedge clk) begin
        dec <= d;
        if (!rst_n) begin
            dec.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- logic/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  mips_core_pkg::dec_t    dec,
    output mips_core_pkg::fwd_t    ex_fwd,
    output mips_core_pkg::retire_t res,
    output logic                   res_valid
);
    import mips_core_pkg::*;

    word_t      alu_res;
    logic [4:0] shamt;
    logic       mov_ok;
    logic       wr_en;

    assign shamt = dec.opr1[4:0];

    always_comb begin
        case (dec.alu_op)
            ADD:     alu_res = dec.opr1 + dec.opr2;
            SUB:     alu_res = dec.opr1 - dec.opr2;
            AND:     alu_res = dec.opr1 & dec.opr2;
            OR:      alu_res = dec.opr1 | dec.opr2;
            XOR:     alu_res = dec.opr1 ^ dec.opr2;
            NOR:     alu_res = ~(dec.opr1 | dec.opr2);
            SLT:     alu_res = word_t'($signed(dec.opr1) < $signed(dec.opr2));
            SLTU:    alu_res = word_t'(dec.opr1 < dec.opr2);
            SLL:     alu_res = dec.opr2 << shamt;
            SRL:     alu_res = dec.opr2 >> shamt;
            SRA:     alu_res = word_t'($signed(dec.opr2) >>> shamt);
            MOV:     alu_res = dec.opr1;
            LINK:    alu_res = dec.pc + 32'd8;  // return past the next word.
            default: alu_res = '0;
        endcase
    end

    // movz writes on rt == 0, movn on rt != 0.
    assign mov_ok = ((dec.opr2 == '0) == dec.mov_on_zero);
    assign wr_en  = dec.wr_en && (!dec.is_mov || mov_ok);

    assign ex_fwd = '{
        wr_en:   dec.valid && wr_en,
        wr_addr: dec.wr_addr,
        data:    alu_res
    };

    always_ff @(posedge clk) begin
        res <= '{
            pc:        dec.pc,
            illegal:   dec.illegal,
            wr_en:     wr_en,
            wr_addr:   dec.wr_addr,
            wr_data:   alu_res,
            is_branch: dec.is_branch,
            br_taken:  dec.br_taken,
            br_target: dec.br_target
        };
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= dec.valid;
        end
    end

endmodule

`default_nettype wire

//--- logic/result_stage.sv
`timescale 1ns/10ps
`default_nettype none

module result_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  mips_core_pkg::retire_t   res,
    input  logic                     res_valid,
    input  mips_core_pkg::reg_addr_t r1_addr,
    output mips_core_pkg::word_t     r1_data,
    input  mips_core_pkg::reg_addr_t r2_addr,
    output mips_core_pkg::word_t     r2_data,
    output mips_core_pkg::fwd_t      wb_fwd,
    output mips_core_pkg::retire_t   retire,
    output logic                     retire_valid
);
    import mips_core_pkg::*;

    word_t regs [NUM_GPR];
    logic  rf_we;

    assign rf_we = res_valid && res.wr_en && (res.wr_addr != '0);  // $zero stays zero.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_GPR; i++) begin
                regs[i] <= '0;
            end
        end else if (rf_we) begin
            regs[res.wr_addr] <= res.wr_data;
        end
    end

    assign r1_data = (r1_addr == '0) ? '0 : regs[r1_addr];
    assign r2_data = (r2_addr == '0) ? '0 : regs[r2_addr];

    assign wb_fwd = '{
        wr_en:   rf_we,
        wr_addr: res.wr_addr,
        data:    res.wr_data
    };

    assign retire       = res;
    assign retire_valid = res_valid;

endmodule

`default_nettype wire

//--- logic/mips_core_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  mips_core_pkg::fetch_t  in_inst,
    output logic                   credit,
    output logic                   retire_valid,
    output mips_core_pkg::retire_t retire
);
    import mips_core_pkg::*;

    logic      q_valid;
    fetch_t    q_inst;
    reg_addr_t r1_addr;
    reg_addr_t r2_addr;
    word_t     r1_data;
    word_t     r2_data;
    fwd_t      ex_fwd;
    fwd_t      wb_fwd;
    dec_t      dec;
    retire_t   res;
    logic      res_valid;

    inst_queue u_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_inst   (in_inst),
        .out_valid (q_valid),
        .out_inst  (q_inst),
        .credit    (credit)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (q_valid),
        .in_inst  (q_inst),
        .r1_addr  (r1_addr),
        .r1_data  (r1_data),
        .r2_addr  (r2_addr),
        .r2_data  (r2_data),
        .ex_fwd   (ex_fwd),
        .wb_fwd   (wb_fwd),
        .dec      (dec)
    );

    execute_stage u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .dec       (dec),
        .ex_fwd    (ex_fwd),
        .res       (res),
        .res_valid (res_valid)
    );

    result_stage u_result (
        .clk          (clk),
        .rst_n        (rst_n),
        .res          (res),
        .res_valid    (res_valid),
        .r1_addr      (r1_addr),
        .r1_data      (r1_data),
        .r2_addr      (r2_addr),
        .r2_data      (r2_data),
        .wb_fwd       (wb_fwd),
        .retire       (retire),
        .retire_valid (retire_valid)
    );

endmodule

`default_nettype wire

//--- testbench/mips_core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module mips_core_assertions (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       push,
    input logic                       pop,
    input logic [mips_core_pkg::QPTR_W:0] count,
    input logic                       credit,
    input mips_core_pkg::word_t       zero_reg
);
    import mips_core_pkg::*;

    int unsigned fail_count = 0;

    // no credit is left while the queue is full.
    full_push: assert property (@(posedge clk) disable iff (!rst_n)
        push |-> (count != (QPTR_W+1)'(QUEUE_DEPTH)))
        else begin
            $error("push into a full queue");
            fail_count++;
        end

    depth_bound: assert property (@(posedge clk) disable iff (!rst_n)
        count <= (QPTR_W+1)'(QUEUE_DEPTH))
        else begin
            $error("queue count above its depth");
            fail_count++;
        end

    // each credit marks one entry leaving the queue.
    credit_on_pop: assert property (@(posedge clk) disable iff (!rst_n)
        credit |=> (count == $past(count) + (QPTR_W+1)'($past(push)) - (QPTR_W+1)'(1)))
        else begin
            $error("credit raised without a pop");
            fail_count++;
        end

    no_zero_write: assert property (@(posedge clk) disable iff (!rst_n)
        zero_reg == '0)
        else begin
            $error("register 0 written");
            fail_count++;
        end

endmodule

bind inst_queue mips_core_assertions q_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (in_valid),
    .pop      (pop),
    .count    (count),
    .credit   (credit),
    .zero_reg (32'd0)
);

bind result_stage mips_core_assertions rf_chk (
    .clk      (clk),
    .rst_n    (rst_n),
    .push     (1'b0),
    .pop      (1'b0),
    .count    ('0),
    .credit   (1'b0),
    .zero_reg (regs[0])
);

`default_nettype wire

//--- testbench/tb_mips_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_core;
    import mips_core_pkg::*;

    localparam int NUM_INST    = 2000;
    localparam int STALL_LIMIT = 100;
    localparam int DRAIN_LIMIT = 100;

    localparam logic [5:0] KEPT_FUNCTS [20] = '{
        SP_SLL, SP_SRL, SP_SRA, SP_SLLV, SP_SRLV, SP_SRAV, SP_ADD, SP_ADDU, SP_SUB, SP_SUBU,
        SP_AND, SP_OR, SP_XOR, SP_NOR, SP_SLT, SP_SLTU, SP_MOVZ, SP_MOVN, SP_JR, SP_JALR
    };
    localparam logic [4:0] REGIMM_RT [4] = '{RI_BLTZ, RI_BGEZ, RI_BLTZAL, RI_BGEZAL};

    logic    clk;
    logic    rst_n;
    logic    in_valid;
    fetch_t  in_inst;
    logic    credit;
    logic    retire_valid;
    retire_t retire;

    word_t   model_regs [32];
    retire_t exp_mem [NUM_INST];
    int      n_pushed = 0;
    int      n_retired = 0;
    int      spent = 0;
    int      returned = 0;
    int      check_errors = 0;
    int      timeouts = 0;

    mips_core_top dut0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .credit       (credit),
        .retire_valid (retire_valid),
        .retire       (retire)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_eq(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            check_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // hot registers make back-to-back dependences common.
    function automatic reg_addr_t pick_reg();
        int unsigned r;
        r = $urandom_range(0, 9);
        if (r < 6) begin
            return reg_addr_t'(r);
        end
        if (r < 8) begin
            return GPR_RA;
        end
        return reg_addr_t'($urandom);
    endfunction

    function automatic logic [31:0] gen_inst();
        int unsigned kind;
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [15:0] imm;
        reg_addr_t   rs;
        reg_addr_t   rt;
        reg_addr_t   rd;
        kind = $urandom_range(0, 99);
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        sa   = '0;
        imm  = 16'($urandom);
        if (imm[14]) begin
            imm = {{12{imm[15]}}, imm[3:0]};  // small values around zero.
        end
        if (kind < 3) begin
            return {6'h10 + 6'($urandom_range(0, 47)), 26'($urandom)};  // cop, loads, stores.
        end
        if (kind < 5) begin
            return {OP_SPECIAL, 20'($urandom), 6'h10 + 6'($urandom_range(0, 11))};  // hi/lo, mul.
        end
        if (kind < 45) begin
            fn = KEPT_FUNCTS[$urandom_range(0, 19)];
            if (fn == SP_SLL || fn == SP_SRL || fn == SP_SRA) begin
                rs = '0;
                sa = 5'($urandom);
            end
            if (fn == SP_JR || fn == SP_JALR) begin
                rt = '0;
            end
            if (fn == SP_JR) begin
                rd = '0;
            end
            return {OP_SPECIAL, rs, rt, rd, sa, fn};
        end
        if (kind < 75) begin
            op = OP_ADDI + 6'($urandom_range(0, 7));
            if (op == OP_LUI) begin
                rs = '0;
            end
            return {op, rs, rt, imm};
        end
        if (kind < 87) begin
            op = OP_BEQ + 6'($urandom_range(0, 3));
            if (op == OP_BLEZ || op == OP_BGTZ) begin
                rt = '0;
            end
            return {op, rs, rt, imm};
        end
        if (kind < 95) begin
            return {OP_REGIMM, rs, REGIMM_RT[$urandom_range(0, 3)], imm};
        end
        return {($urandom_range(0, 1) != 0) ? OP_JAL : OP_J, 26'($urandom)};
    endfunction

    // architectural result of one instruction, in program order.
    task automatic model_step(input word_t pc, input logic [31:0] iw, output retire_t e);
        logic [5:0] op;
        logic [5:0] fn;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] sa;
        word_t      a;
        word_t      b;
        word_t      se;
        word_t      ze;
        word_t      pc4;
        logic       ok;
        op  = iw[31:26];
        rs  = iw[25:21];
        rt  = iw[20:16];
        rd  = iw[15:11];
        sa  = iw[10:6];
        fn  = iw[5:0];
        a   = model_regs[rs];
        b   = model_regs[rt];
        se  = {{16{iw[15]}}, iw[15:0]};
        ze  = {16'h0000, iw[15:0]};
        pc4 = pc + 32'd4;
        ok  = 1'b1;
        e   = '0;
        e.pc = pc;
        case (op)
            OP_SPECIAL: begin
                e.wr_en   = 1'b1;
                e.wr_addr = rd;
                ok = (fn == SP_SLL || fn == SP_SRL || fn == SP_SRA) ? (rs == '0) : (sa == '0);
                case (fn)
                    SP_SLL:          e.wr_data = b << sa;
                    SP_SRL:          e.wr_data = b >> sa;
                    SP_SRA:          e.wr_data = $signed(b) >>> sa;
                    SP_SLLV:         e.wr_data = b << a[4:0];
                    SP_SRLV:         e.wr_data = b >> a[4:0];
                    SP_SRAV:         e.wr_data = $signed(b) >>> a[4:0];
                    SP_ADD, SP_ADDU: e.wr_data = a + b;
                    SP_SUB, SP_SUBU: e.wr_data = a - b;
                    SP_AND:          e.wr_data = a & b;
                    SP_OR:           e.wr_data = a | b;
                    SP_XOR:          e.wr_data = a ^ b;
                    SP_NOR:          e.wr_data = ~(a | b);
                    SP_SLT:          e.wr_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    SP_SLTU:         e.wr_data = (a < b) ? 32'd1 : 32'd0;
                    SP_MOVZ, SP_MOVN: begin
                        e.wr_data = a;
                        e.wr_en   = (fn == SP_MOVZ) ? (b == '0) : (b != '0);
                    end
                    SP_JR, SP_JALR: begin
                        ok          = (rt == '0) && (sa == '0) && (fn == SP_JALR || rd == '0);
                        e.wr_en     = (fn == SP_JALR);
                        e.wr_data   = pc + 32'd8;
                        e.is_branch = 1'b1;
                        e.br_taken  = 1'b1;
                        e.br_target = a;
                    end
                    default:         ok = 1'b0;
                endcase
            end
            OP_REGIMM: begin
                ok = (rt == RI_BLTZ || rt == RI_BGEZ || rt == RI_BLTZAL || rt == RI_BGEZAL);
                e.is_branch = 1'b1;
                e.br_taken  = (rt == RI_BGEZ || rt == RI_BGEZAL) ? ($signed(a) >= 0)
                                                                 : ($signed(a) < 0);
                e.br_target = pc4 + (se << 2);
                e.wr_en     = (rt == RI_BLTZAL || rt == RI_BGEZAL);
                e.wr_addr   = GPR_RA;
                e.wr_data   = pc + 32'd8;
            end
            OP_J, OP_JAL: begin
                e.is_branch = 1'b1;
                e.br_taken  = 1'b1;
                e.br_target = {pc4[31:28], iw[25:0], 2'b00};  // stays in the 256 MB region.
                e.wr_en     = (op == OP_JAL);
                e.wr_addr   = GPR_RA;
                e.wr_data   = pc + 32'd8;
            end
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                e.is_branch = 1'b1;
                e.br_target = pc4 + (se << 2);
                case (op)
                    OP_BEQ:  e.br_taken = (a == b);
                    OP_BNE:  e.br_taken = (a != b);
                    OP_BLEZ: e.br_taken = ($signed(a) <= 0);
                    default: e.br_taken = ($signed(a) > 0);
                endcase
                ok = (op == OP_BEQ || op == OP_BNE || rt == '0);
            end
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                e.wr_en   = 1'b1;
                e.wr_addr = rt;
                case (op)
                    OP_ADDI, OP_ADDIU: e.wr_data = a + se;
                    OP_SLTI:           e.wr_data = ($signed(a) < $signed(se)) ? 32'd1 : 32'd0;
                    OP_SLTIU:          e.wr_data = (a < se) ? 32'd1 : 32'd0;
                    OP_ANDI:           e.wr_data = a & ze;
                    OP_ORI:            e.wr_data = a | ze;
                    OP_XORI:           e.wr_data = a ^ ze;
                    default:           e.wr_data = {iw[15:0], 16'h0000};
                endcase
                ok = (op != OP_LUI || rs == '0);
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            e         = '0;
            e.pc      = pc;
            e.illegal = 1'b1;
        end
        if (e.wr_en && e.wr_addr != '0) begin
            model_regs[e.wr_addr] = e.wr_data;
        end
    endtask

    task automatic check_retire();
        retire_t e;
        string   tag;
        if (n_retired >= n_pushed) begin
            check_errors++;
            $display("retire at %0t with no instruction outstanding", $time);
        end else begin
            e   = exp_mem[n_retired];
            tag = $sformatf("pc %h", e.pc);
            n_retired++;
            check_eq({tag, " pc"}, retire.pc, e.pc);
            check_eq({tag, " illegal"}, word_t'(retire.illegal), word_t'(e.illegal));
            check_eq({tag, " wr_en"}, word_t'(retire.wr_en), word_t'(e.wr_en));
            if (e.wr_en) begin
                check_eq({tag, " wr_addr"}, word_t'(retire.wr_addr), word_t'(e.wr_addr));
                check_eq({tag, " wr_data"}, retire.wr_data, e.wr_data);
            end
            check_eq({tag, " is_branch"}, word_t'(retire.is_branch), word_t'(e.is_branch));
            check_eq({tag, " br_taken"}, word_t'(retire.br_taken), word_t'(e.br_taken));
            if (e.is_branch) begin
                check_eq({tag, " br_target"}, retire.br_target, e.br_target);
            end
        end
    endtask

    // outputs settle after the rising edge, so look at them on the falling one.
    always @(negedge clk) begin
        if (!rst_n) begin
            check_eq("credit in reset", word_t'(credit), '0);
            check_eq("retire_valid in reset", word_t'(retire_valid), '0);
        end else begin
            if (credit) begin
                returned++;
            end
            if (retire_valid) begin
                check_retire();
            end
        end
    end

    initial begin
        word_t       pc;
        logic [31:0] iw;
        int          stall;
        int          wait_cnt;
        int unsigned gap_pct;
        int          asrt_fails;
        void'($urandom(32'hc1b4));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_inst  = '0;
        pc       = 32'hbfc0_0000;
        stall    = 0;
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // alternate gappy and full-credit phases.
        while (n_pushed < NUM_INST && stall < STALL_LIMIT) begin
            @(posedge clk);
            gap_pct = ((n_pushed / 250) % 2 == 1) ? 0 : 50;
            if (QUEUE_DEPTH + returned - spent <= 0) begin
                in_valid <= 1'b0;
                stall++;
            end else if ($urandom_range(0, 99) >= gap_pct) begin
                iw = gen_inst();
                model_step(pc, iw, exp_mem[n_pushed]);
                in_valid <= 1'b1;
                in_inst  <= {pc, iw};
                spent++;
                n_pushed++;
                pc    = pc + 32'd4;
                stall = 0;
            end else begin
                in_valid <= 1'b0;
                stall    = 0;
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        if (stall >= STALL_LIMIT) begin
            timeouts++;
            $display("timeout: no credit came back for %0d cycles", STALL_LIMIT);
        end

        wait_cnt = 0;
        while ((n_retired != n_pushed || QUEUE_DEPTH + returned - spent != QUEUE_DEPTH) &&
               wait_cnt < DRAIN_LIMIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (wait_cnt >= DRAIN_LIMIT) begin
            timeouts++;
            $display("timeout: %0d of %0d retired, %0d credits held when idle",
                     n_retired, n_pushed, QUEUE_DEPTH + returned - spent);
        end
        @(negedge clk);

        asrt_fails = int'(dut0.u_queue.q_chk.fail_count + dut0.u_result.rf_chk.fail_count);
        $display("errors: %0d check, %0d timeout, %0d assertion (%0d retired)",
                 check_errors, timeouts, asrt_fails, n_retired);
        if (check_errors == 0 && timeouts == 0 && asrt_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
logic/mips_core_pkg.sv
logic/inst_queue.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/result_stage.sv
logic/mips_core_top.sv
testbench/mips_core_assertions.sv
testbench/tb_mips_core.sv

//--- Makefile
SIM := obj_dir/Vtb_mips_core

.PHONY: all run clean

all: run

$(SIM): project.f $(shell cat project.f)
	verilator --binary --timing --assert -j 0 --top-module tb_mips_core -f project.f

run: $(SIM)
	@out="$$($(SIM) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '** PASS **'

clean:
	rm -rf obj_dir
